// ==== Makefile ====
TOP = relay_computer_tb

.PHONY: all build lint clean

# build, run and look for the pass line in the output
all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== files.f ====
logic/relay_isa_pkg.sv
logic/relay_link_pkg.sv
logic/program_memory.sv
logic/relay_cpu.sv
logic/trace_sender.sv
logic/relay_computer_top.sv
sim/relay_computer_sva.sv
sim/relay_computer_tb.sv

// ==== logic/program_memory.sv ====
`timescale 1ns/1ps

module program_memory (
	input logic transaction_clock,
	input logic reset,
	input relay_link_pkg::load_beat_t load,
	output logic load_done,
	input relay_isa_pkg::addr_t core_addr,
	input logic core_write,
	input relay_isa_pkg::data_t core_wdata,
	output relay_isa_pkg::data_t core_rdata
);
	import relay_isa_pkg::*;

	// unified code and data storage
	data_t mem [mem_depth];

	// next address for a load beat
	addr_t load_addr;

	logic load_write;
	logic core_write_en;

	// load beats count only until the image is complete
	assign load_write = load.valid && !load_done;

	// core port is live once loading has finished
	assign core_write_en = core_write && load_done;

	// load address counter and completion flag
	always_ff @(posedge transaction_clock)
	begin
		if (reset)
		begin
			load_addr <= '0;
			load_done <= 1'b0;
		end
		else if (load_write)
		begin
			load_addr <= load_addr + 5'd1;
			// done shows up one cycle after the last beat
			if (load.last)
				load_done <= 1'b1;
		end
	end

	// single write port shared by loader and core
	always_ff @(posedge transaction_clock)
	begin
		if (load_write)
			mem[load_addr] <= load.data;
		else if (core_write_en)
			mem[core_addr] <= core_wdata;
	end

	// registered read with one cycle of latency
	// a write to the same address returns the old byte
	always_ff @(posedge transaction_clock)
	begin
		core_rdata <= mem[core_addr];
	end

endmodule

// ==== logic/relay_computer_top.sv ====
`timescale 1ns/1ps

module relay_computer_top (
	input logic transaction_clock,
	input logic reset,
	input relay_link_pkg::load_beat_t load,
	input logic trace_credit,
	output logic trace_valid,
	output relay_link_pkg::trace_record_t trace_record,
	output logic halted
);
	import relay_isa_pkg::*;
	import relay_link_pkg::*;

	// memory to core
	logic load_done;
	addr_t mem_addr;
	logic mem_write;
	data_t mem_wdata;
	data_t mem_rdata;

	// core to trace sender
	logic report_valid;
	trace_record_t report_record;
	logic report_ready;

	// unified program and data memory
	program_memory i_program_memory (
		.transaction_clock(transaction_clock),
		.reset(reset),
		.load(load),
		.load_done(load_done),
		.core_addr(mem_addr),
		.core_write(mem_write),
		.core_wdata(mem_wdata),
		.core_rdata(mem_rdata)
	);

	// relay computer core
	relay_cpu i_relay_cpu (
		.transaction_clock(transaction_clock),
		.reset(reset),
		.load_done(load_done),
		.mem_addr(mem_addr),
		.mem_write(mem_write),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.report_valid(report_valid),
		.report_record(report_record),
		.report_ready(report_ready),
		.halted(halted)
	);

	// credit flow on the trace port
	trace_sender i_trace_sender (
		.transaction_clock(transaction_clock),
		.reset(reset),
		.report_valid(report_valid),
		.report_record(report_record),
		.report_ready(report_ready),
		.trace_credit(trace_credit),
		.trace_valid(trace_valid),
		.trace_record(trace_record)
	);

endmodule

// ==== logic/relay_cpu.sv ====
`timescale 1ns/1ps

module relay_cpu (
	input logic transaction_clock,
	input logic reset,
	input logic load_done,
	output relay_isa_pkg::addr_t mem_addr,
	output logic mem_write,
	output relay_isa_pkg::data_t mem_wdata,
	input relay_isa_pkg::data_t mem_rdata,
	output logic report_valid,
	output relay_link_pkg::trace_record_t report_record,
	input logic report_ready,
	output logic halted
);
	import relay_isa_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_execute,
		st_jump_target,
		st_mem_access,
		st_report,
		st_halted
	} state_t;

	state_t state;

	// architectural state
	addr_t pc;
	data_t reg_file [4];
	flags_t flags;

	// opcode kept for the states after execute
	data_t ir;

	// decode of the byte on the read port during execute
	op_group_t op_group;
	sys_op_t sys_op;
	alu_func_t alu_func;
	reg_sel_t mov_src;
	reg_sel_t mov_dst;
	reg_sel_t mem_reg;
	data_t imm;

	// alu result with carry out in bit 8
	logic [8:0] alu_wide;
	flags_t alu_flags;

	logic goto_taken;

	assign op_group = op_group_t'(mem_rdata[7:6]);
	assign sys_op = sys_op_t'(mem_rdata[5:4]);
	assign alu_func = alu_func_t'(mem_rdata[2:0]);
	assign mov_src = reg_sel_t'(mem_rdata[1:0]);
	assign mov_dst = reg_sel_t'(mem_rdata[3:2]);
	assign mem_reg = reg_sel_t'(mem_rdata[1:0]);

	// setab immediate sign extended from bit 4
	assign imm = {{3{mem_rdata[4]}}, mem_rdata[4:0]};

	// goto condition from the held opcode
	// bit 3 forces the jump and bits 2 to 0 mask sign, carry and zero
	assign goto_taken = ir[3]
		|| (ir[2] && flags.sign)
		|| (ir[1] && flags.carry)
		|| (ir[0] && flags.zero);

	// alu reads b and c
	always_comb
	begin
		case (alu_func)
			alu_add: alu_wide = {1'b0, reg_file[reg_b]} + {1'b0, reg_file[reg_c]};
			alu_inc: alu_wide = {1'b0, reg_file[reg_b]} + 9'd1;
			alu_and: alu_wide = {1'b0, reg_file[reg_b] & reg_file[reg_c]};
			alu_or: alu_wide = {1'b0, reg_file[reg_b] | reg_file[reg_c]};
			alu_xor: alu_wide = {1'b0, reg_file[reg_b] ^ reg_file[reg_c]};
			alu_not: alu_wide = {1'b0, ~reg_file[reg_b]};
			alu_rol: alu_wide = {1'b0, reg_file[reg_b][6:0], reg_file[reg_b][7]};
			alu_clr: alu_wide = '0;
		endcase
		// carry is only ever set by add and inc
		alu_flags.sign = alu_wide[7];
		alu_flags.carry = alu_wide[8];
		alu_flags.zero = (alu_wide[7:0] == 8'd0);
	end

	// memory port
	// fetch reads at pc and execute reads the goto target or the d address
	always_comb
	begin
		mem_addr = pc;
		mem_write = 1'b0;
		mem_wdata = reg_file[mem_reg];
		if (state == st_execute && op_group == op_system)
		begin
			if (sys_op == sys_goto)
				mem_addr = pc + 5'd1;
			else
				mem_addr = reg_file[reg_d][4:0];
			// store writes in the same cycle
			mem_write = (sys_op == sys_store);
		end
	end

	// opcode capture for goto and load
	always_ff @(posedge transaction_clock)
	begin
		if (state == st_execute)
			ir <= mem_rdata;
	end

	// fsm and register file
	always_ff @(posedge transaction_clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			pc <= '0;
			flags <= '0;
			halted <= 1'b0;
			for (int i = 0; i < 4; i++)
				reg_file[i] <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					// start at address 0 once the image is in
					if (load_done)
						state <= st_fetch;
				end
				st_fetch:
				begin
					state <= st_execute;
				end
				st_execute:
				begin
					// every opcode is one byte and goto adds its target later
					pc <= pc + 5'd1;
					state <= st_report;
					case (op_group)
						op_mov8:
						begin
							reg_file[mov_dst] <= reg_file[mov_src];
						end
						op_setab:
						begin
							if (mem_rdata[5])
								reg_file[reg_b] <= imm;
							else
								reg_file[reg_a] <= imm;
						end
						op_alu:
						begin
							if (mem_rdata[3])
								reg_file[reg_d] <= alu_wide[7:0];
							else
								reg_file[reg_a] <= alu_wide[7:0];
							flags <= alu_flags;
						end
						op_system:
						begin
							case (sys_op)
								sys_load: state <= st_mem_access;
								sys_goto: state <= st_jump_target;
								// halt retires like any one-byte opcode
								sys_halt: halted <= 1'b1;
								default: state <= st_report;
							endcase
						end
					endcase
				end
				st_jump_target:
				begin
					// target byte is on the read port now
					if (goto_taken)
						pc <= mem_rdata[4:0];
					else
						pc <= pc + 5'd1;
					state <= st_report;
				end
				st_mem_access:
				begin
					reg_file[reg_sel_t'(ir[1:0])] <= mem_rdata;
					state <= st_report;
				end
				st_report:
				begin
					// wait here for a credit with the state frozen
					if (report_ready)
						state <= halted ? st_halted : st_fetch;
				end
				st_halted:
				begin
					state <= st_halted;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// record offer stays stable while waiting in report
	assign report_valid = (state == st_report);

	always_comb
	begin
		report_record.pc = pc;
		report_record.a = reg_file[reg_a];
		report_record.b = reg_file[reg_b];
		report_record.c = reg_file[reg_c];
		report_record.d = reg_file[reg_d];
		report_record.flags = flags;
		report_record.halted = halted;
	end

endmodule

// ==== logic/relay_isa_pkg.sv ====
package relay_isa_pkg;

	// one register or memory byte
	typedef logic [7:0] data_t;

	// byte address into the unified memory
	typedef logic [4:0] addr_t;

	// memory size in bytes
	localparam int mem_depth = 32;

	// register select as encoded in the instruction
	typedef logic [1:0] reg_sel_t;

	localparam reg_sel_t reg_a = 2'd0;
	localparam reg_sel_t reg_b = 2'd1;
	localparam reg_sel_t reg_c = 2'd2;
	localparam reg_sel_t reg_d = 2'd3;

	// instruction group in bits 7 to 6
	typedef enum logic [1:0] {
		op_mov8 = 2'b00,
		op_setab = 2'b01,
		op_alu = 2'b10,
		op_system = 2'b11
	} op_group_t;

	// system group operation in bits 5 to 4
	typedef enum logic [1:0] {
		sys_load = 2'b00,
		sys_store = 2'b01,
		sys_goto = 2'b10,
		sys_halt = 2'b11
	} sys_op_t;

	// alu function in bits 2 to 0 on operands b and c
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_inc = 3'd1,
		alu_and = 3'd2,
		alu_or = 3'd3,
		alu_xor = 3'd4,
		alu_not = 3'd5,
		alu_rol = 3'd6,
		alu_clr = 3'd7
	} alu_func_t;

	// bit order matches the goto condition mask
	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
	} flags_t;

endpackage

// ==== logic/relay_link_pkg.sv ====
package relay_link_pkg;

	// one program byte from the host
	typedef struct packed {
		logic valid;
		relay_isa_pkg::data_t data;
		logic last;
	} load_beat_t;

	// architectural state after one retired instruction
	typedef struct packed {
		relay_isa_pkg::addr_t pc;
		relay_isa_pkg::data_t a;
		relay_isa_pkg::data_t b;
		relay_isa_pkg::data_t c;
		relay_isa_pkg::data_t d;
		relay_isa_pkg::flags_t flags;
		logic halted;
	} trace_record_t;

	// records the consumer can buffer
	localparam int trace_credits = 4;

	// counter must hold the full credit value
	localparam int credit_width = $clog2(trace_credits + 1);

	typedef logic [credit_width-1:0] credit_count_t;

endpackage

// ==== logic/trace_sender.sv ====
`timescale 1ns/1ps

module trace_sender (
	input logic transaction_clock,
	input logic reset,
	input logic report_valid,
	input relay_link_pkg::trace_record_t report_record,
	output logic report_ready,
	input logic trace_credit,
	output logic trace_valid,
	output relay_link_pkg::trace_record_t trace_record
);
	import relay_link_pkg::*;

	// records the consumer can still take
	credit_count_t credits;

	logic accept;

	// ready only while a credit is left
	assign report_ready = (credits != '0);
	assign accept = report_valid && report_ready;

	// credit counter and beat valid
	always_ff @(posedge transaction_clock)
	begin
		if (reset)
		begin
			credits <= credit_count_t'(trace_credits);
			trace_valid <= 1'b0;
		end
		else
		begin
			// one cycle beat after each acceptance
			trace_valid <= accept;
			case ({accept, trace_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				// both or neither leave the count alone
				default: credits <= credits;
			endcase
		end
	end

	// output record register
	// only sampled when valid follows
	always_ff @(posedge transaction_clock)
	begin
		if (accept)
			trace_record <= report_record;
	end

endmodule

// ==== sim/relay_computer_sva.sv ====
`timescale 1ns/1ps

module relay_computer_sva (
	input logic transaction_clock,
	input logic reset,
	input logic report_valid,
	input logic report_ready,
	input relay_link_pkg::trace_record_t report_record,
	input logic trace_valid,
	input relay_link_pkg::trace_record_t trace_record,
	input relay_link_pkg::credit_count_t credits
);
	import relay_link_pkg::*;

	// high once the record with halted set has left the port
	logic halt_sent;

	always_ff @(posedge transaction_clock)
	begin
		if (reset)
			halt_sent <= 1'b0;
		else if (trace_valid && trace_record.halted)
			halt_sent <= 1'b1;
	end

	// consumer never holds more records than it can buffer
	credit_limit: assert property (@(posedge transaction_clock) disable iff (reset)
		credits <= credit_count_t'(trace_credits))
		else $error("credit count above the consumer buffer size");

	// port goes quiet after the halted record
	quiet_after_halt: assert property (@(posedge transaction_clock) disable iff (reset)
		halt_sent |-> !trace_valid && !report_valid)
		else $error("trace activity after the halted record");

	// offer held steady while no credit is left
	offer_held: assert property (@(posedge transaction_clock) disable iff (reset)
		report_valid && !report_ready |=> report_valid && $stable(report_record))
		else $error("report offer changed while waiting for a credit");

	// full credit and an idle port right after reset
	reset_values: assert property (@(posedge transaction_clock)
		reset |=> credits == credit_count_t'(trace_credits) && !trace_valid)
		else $error("credit count or trace_valid wrong after reset");

endmodule

// ==== sim/relay_computer_tb.sv ====
`timescale 1ns/1ps

module relay_computer_tb;
	import relay_isa_pkg::*;
	import relay_link_pkg::*;

	localparam int program_count = 40;
	localparam int cycles_per_program = 400;
	localparam int timeout_cycles = program_count * cycles_per_program;

	logic transaction_clock;
	logic reset;
	load_beat_t load;
	logic trace_credit;
	logic trace_valid;
	trace_record_t trace_record;
	logic halted;

	logic [31:0] rng_state;
	// current program image including the data region
	data_t image [mem_depth];
	trace_record_t expected [$];
	// cycle at which each held credit goes back, strictly rising
	int credit_due [$];
	int outstanding;
	int cycle_count;
	int program_index;
	int record_index;
	logic halt_seen;
	int value_errors;
	int protocol_errors;

	relay_computer_top i_dut (
		.transaction_clock(transaction_clock),
		.reset(reset),
		.load(load),
		.trace_credit(trace_credit),
		.trace_valid(trace_valid),
		.trace_record(trace_record),
		.halted(halted)
	);

	bind trace_sender relay_computer_sva i_relay_computer_sva (
		.transaction_clock(transaction_clock),
		.reset(reset),
		.report_valid(report_valid),
		.report_ready(report_ready),
		.report_record(report_record),
		.trace_valid(trace_valid),
		.trace_record(trace_record),
		.credits(credits)
	);

	// 20 ns period
	always #10 transaction_clock = ~transaction_clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned random_below(input int unsigned bound);
		rng_state = xorshift32(rng_state);
		return rng_state % bound;
	endfunction

	// random program of whole units with halt last and forward gotos only
	task automatic build_program();
		int pos;
		int limit;
		int kind;
		int halt_pos;
		int target;
		int count;
		int pick;
		logic unit_start [mem_depth];
		int goto_at [$];
		for (int i = 0; i < mem_depth; i++)
		begin
			image[i] = data_t'(random_below(256));
			unit_start[i] = 1'b0;
		end
		limit = 6 + int'(random_below(18));
		pos = 0;
		while (pos < limit)
		begin
			unit_start[pos] = 1'b1;
			kind = int'(random_below(7));
			// fall back to one alu byte when a 3 byte memory unit or 2 byte goto won't fit
			if (kind >= 4 && pos + ((kind == 6) ? 2 : 3) > limit)
				kind = 2;
			case (kind)
				0: image[pos] = {2'b00, 6'(random_below(64))};
				1: image[pos] = {2'b01, 6'(random_below(64))};
				2, 3: image[pos] = {2'b10, 6'(random_below(64))};
				4, 5:
				begin
					// b gets -8..-1 and d copies it so the access hits 24..31
					image[pos] = {3'b011, 2'b11, 3'(random_below(8))};
					image[pos + 1] = 8'h0d;
					image[pos + 2] = {2'b11, (kind == 4) ? 2'b00 : 2'b01, 4'(random_below(16))};
				end
				default:
				begin
					image[pos] = {4'b1110, 4'(random_below(16))};
					goto_at.push_back(pos);
				end
			endcase
			pos = pos + ((kind >= 4) ? ((kind == 6) ? 2 : 3) : 1);
		end
		halt_pos = pos;
		image[halt_pos] = 8'hf0;
		unit_start[halt_pos] = 1'b1;
		// target is any unit start after the target byte up to and including halt
		foreach (goto_at[g])
		begin
			count = 0;
			target = halt_pos;
			for (int i = goto_at[g] + 2; i <= halt_pos; i++)
				if (unit_start[i])
					count++;
			pick = int'(random_below(count));
			for (int i = goto_at[g] + 2; i <= halt_pos; i++)
			begin
				if (unit_start[i] && pick == 0)
					target = i;
				if (unit_start[i])
					pick--;
			end
			image[goto_at[g] + 1] = data_t'(target);
		end
	endtask

	// reference model with one expected record per retired instruction
	task automatic run_model();
		data_t mm [mem_depth];
		data_t r [4];
		flags_t f;
		addr_t pc;
		data_t op;
		int sum;
		data_t res;
		logic taken;
		logic done;
		int steps;
		trace_record_t rec;
		for (int i = 0; i < mem_depth; i++)
			mm[i] = image[i];
		for (int i = 0; i < 4; i++)
			r[i] = '0;
		f = '0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		expected.delete();
		while (!done && steps < 64)
		begin
			op = mm[pc];
			pc = pc + 5'd1;
			case (op[7:6])
				2'b00: r[op[3:2]] = r[op[1:0]];
				2'b01:
				begin
					// negative immediates sit 32 below their raw 5-bit code
					if (op[4])
						r[op[5] ? reg_b : reg_a] = {3'b000, op[4:0]} - 8'd32;
					else
						r[op[5] ? reg_b : reg_a] = {3'b000, op[4:0]};
				end
				2'b10:
				begin
					// carry is whatever the full int result holds above 255
					case (op[2:0])
						3'd0: sum = r[reg_b] + r[reg_c];
						3'd1: sum = r[reg_b] + 1;
						3'd2: sum = r[reg_b] & r[reg_c];
						3'd3: sum = r[reg_b] | r[reg_c];
						3'd4: sum = r[reg_b] ^ r[reg_c];
						3'd5: sum = 255 - r[reg_b];
						3'd6: sum = (r[reg_b] * 2) % 256 + r[reg_b] / 128;
						default: sum = 0;
					endcase
					res = data_t'(sum);
					r[op[3] ? reg_d : reg_a] = res;
					f.sign = res[7];
					f.carry = (sum > 255);
					f.zero = (res == 8'd0);
				end
				default:
				begin
					case (op[5:4])
						2'b00: r[op[1:0]] = mm[r[reg_d][4:0]];
						2'b01: mm[r[reg_d][4:0]] = r[op[1:0]];
						2'b10:
						begin
							// pc now points at the target byte
							taken = op[3] || (op[2] && f.sign) || (op[1] && f.carry)
								|| (op[0] && f.zero);
							if (taken)
								pc = mm[pc][4:0];
							else
								pc = pc + 5'd1;
						end
						default: done = 1'b1;
					endcase
				end
			endcase
			rec.pc = pc;
			rec.a = r[reg_a];
			rec.b = r[reg_b];
			rec.c = r[reg_c];
			rec.d = r[reg_d];
			rec.flags = f;
			rec.halted = done;
			expected.push_back(rec);
			steps++;
		end
	endtask

	task automatic print_error_counts();
		$display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
	endtask

	// one falling edge with trace checks and credit return
	task automatic tick();
		trace_record_t want;
		int due;
		@(negedge transaction_clock);
		cycle_count++;
		trace_credit = 1'b0;
		if (!reset)
		begin
			if (trace_valid)
			begin
				assert (!halt_seen && expected.size() != 0) else
				begin
					$display("ERROR at %0t: trace beat arrived with no record left to expect",
						$time);
					protocol_errors++;
				end
				if (!halt_seen && expected.size() != 0)
				begin
					want = expected.pop_front();
					assert (trace_record == want) else
					begin
						$display("CHECK FAILED at %0t: program %0d record %0d is %h, expected %h",
							$time, program_index, record_index, trace_record, want);
						value_errors++;
					end
					halt_seen = want.halted;
					record_index++;
				end
				// hand the credit back 0 to 8 cycles later
				outstanding++;
				due = cycle_count + int'(random_below(9));
				if (credit_due.size() != 0 && due <= credit_due[$])
					due = credit_due[$] + 1;
				credit_due.push_back(due);
			end
			assert (outstanding <= trace_credits) else
			begin
				$display("CHECK FAILED at %0t: %0d records outstanding, limit %0d", $time,
					outstanding, trace_credits);
				value_errors++;
			end
			assert (!halt_seen || halted) else
			begin
				$display("CHECK FAILED at %0t: halted dropped after the halt record", $time);
				value_errors++;
			end
			if (credit_due.size() != 0 && credit_due[0] <= cycle_count)
			begin
				credit_due.delete(0);
				trace_credit = 1'b1;
				outstanding--;
			end
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		load = '0;
		repeat (5)
			tick();
		assert (!trace_valid && !halted) else
		begin
			$display("CHECK FAILED at %0t: trace_valid or halted high during reset", $time);
			value_errors++;
		end
		reset = 1'b0;
		halt_seen = 1'b0;
		record_index = 0;
	endtask

	// whole image with idle gaps and then one stray beat that must be ignored
	task automatic stream_image();
		for (int i = 0; i < mem_depth; i++)
		begin
			repeat (random_below(4))
			begin
				tick();
				load.valid = 1'b0;
			end
			tick();
			load.valid = 1'b1;
			load.data = image[i];
			load.last = (i == mem_depth - 1);
		end
		tick();
		load.data = ~image[0];
		load.last = 1'b1;
		tick();
		load = '0;
	endtask

	task automatic run_until_drained();
		while (!halt_seen || expected.size() != 0 || credit_due.size() != 0)
			tick();
		// port must stay quiet and halted high
		repeat (4)
			tick();
	endtask

	// cycle limit for the whole run
	initial
	begin
		wait (cycle_count > timeout_cycles);
		$display("timeout: program %0d still running after %0d cycles", program_index,
			timeout_cycles);
		print_error_counts();
		$display("Test failed");
		$finish;
	end

	initial
	begin
		transaction_clock = 1'b0;
		reset = 1'b1;
		load = '0;
		trace_credit = 1'b0;
		rng_state = 32'd44575;
		outstanding = 0;
		cycle_count = 0;
		record_index = 0;
		halt_seen = 1'b0;
		value_errors = 0;
		protocol_errors = 0;
		for (program_index = 0; program_index < program_count; program_index++)
		begin
			build_program();
			run_model();
			apply_reset();
			stream_image();
			run_until_drained();
		end
		print_error_counts();
		if (value_errors == 0 && protocol_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
